// File: verilog.f
hw/mcu_pkg.sv
hw/bus_decoder.sv
hw/ram_bank.sv
hw/bus_resp_mux.sv
hw/soc_ctrl.sv
hw/gpio_ctrl.sv
hw/mini_mcu_top.sv
tests/tb_mini_mcu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mini mcu testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mini_mcu -Mdir obj_dir -o tb_mini_mcu -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_mini_mcu 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
else
  echo "pass line missing from simulation output"
  exit 1
fi

// File: tests/tb_mini_mcu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu testbench: APB tasks, checks,
// directed tests, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_mini_mcu
  import mcu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD_NS = 4;
  localparam int unsigned NUM_XFERS     = 500;
  localparam int unsigned CYCLE_BOUND   = 10;
  localparam int unsigned TIMEOUT_NS    = NUM_XFERS * CYCLE_BOUND * CLK_PERIOD_NS;

  logic                  clk;
  logic                  arst_n;
  apb_req_t              req;
  apb_rsp_t              rsp;
  logic                  boot_sel;
  logic [GPIO_WIDTH-1:0] gpio_in;
  gpio_pads_t            pads;
  logic                  intr;
  logic                  exit_valid;
  word_t                 exit_value;

  int    error_count = 0;
  word_t rng_state   = 32'h0d26_c481;
  word_t ram_model [word_t];

  mini_mcu_top u_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .apb_req_i     (req),
    .apb_rsp_o     (rsp),
    .boot_select_i (boot_sel),
    .gpio_i        (gpio_in),
    .gpio_o        (pads),
    .gpio_intr_o   (intr),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: simulation timed out after %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  function automatic word_t xorshift(input word_t s);
    word_t x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // expected word after a strobed write
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input logic [STRB_WIDTH-1:0] strb);
    word_t res;
    res = old_w;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic word_t ram_addr(input int bank, input int word);
    return RAM_BASE + word_t'(bank) * BANK_BYTES + word_t'(word) * 4;
  endfunction

  task automatic stop_on_error();
    error_count++;
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_err(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s: pslverr %b, expected %b", $time, what, actual,
               expected);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s: got %b, expected %b", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_pads(input gpio_pads_t actual, input gpio_pads_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s: out/oe %h/%h, expected %h/%h", $time, what,
               actual.out, actual.oe, expected.out, expected.oe);
      stop_on_error();
    end
  endtask

  // one APB transfer, setup then access until pready
  task automatic apb_xfer(input logic write, input word_t addr, input word_t wdata,
                          input logic [STRB_WIDTH-1:0] strb, output word_t rdata,
                          output logic err);
    apb_req_t r;
    r = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata, pstrb: strb};
    @(posedge clk);
    req <= r;
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk);
    while (!rsp.pready) @(negedge clk);
    rdata = rsp.prdata;
    err   = rsp.pslverr;
    @(posedge clk);
    req <= '0;
  endtask

  task automatic write_word(input word_t addr, input word_t data,
                            input logic [STRB_WIDTH-1:0] strb);
    word_t rd;
    logic  err;
    apb_xfer(1'b1, addr, data, strb, rd, err);
    check_err(err, 1'b0, $sformatf("write to %h", addr));
  endtask

  task automatic read_expect(input word_t addr, input word_t expected);
    word_t rd;
    logic  err;
    apb_xfer(1'b0, addr, '0, '0, rd, err);
    check_err(err, 1'b0, $sformatf("read of %h", addr));
    check_word(rd, expected, $sformatf("read data of %h", addr));
  endtask

  task automatic test_reset_values();
    @(negedge clk);
    check_flag(rsp.pready, 1'b0, "pready while idle after reset");
    check_err(rsp.pslverr, 1'b0, "idle bus after reset");
    check_pads(pads, '0, "gpio pads after reset");
    check_flag(intr, 1'b0, "gpio interrupt after reset");
    check_flag(exit_valid, 1'b0, "exit valid after reset");
    check_word(exit_value, '0, "exit value after reset");
    read_expect(GPIO_BASE + word_t'(GPIO_OUT_OFS), '0);
    read_expect(SOC_CTRL_BASE + word_t'(EXIT_VALUE_OFS), '0);
  endtask

  task automatic test_ram();
    int    word_idx [3];
    int    order [5];
    word_t addr;
    word_t data;
    word_idx = '{0, BANK_WORDS / 2, BANK_WORDS - 1};
    order    = '{0, 2, 1, 3, 0};
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < 3; w++) begin
        addr = ram_addr(b, word_idx[w]);
        data = next_rand();
        write_word(addr, data, '1);
        ram_model[addr] = data;
      end
    end
    foreach (ram_model[a]) read_expect(a, ram_model[a]);
    // bytes 0 and 2 only
    addr = ram_addr(1, BANK_WORDS / 2);
    data = next_rand();
    write_word(addr, data, 4'b0101);
    ram_model[addr] = merge_bytes(ram_model[addr], data, 4'b0101);
    read_expect(addr, ram_model[addr]);
    // same local word in every bank
    for (int b = 0; b < NUM_BANKS; b++) begin
      addr = ram_addr(b, 10);
      data = next_rand();
      write_word(addr, data, '1);
      ram_model[addr] = data;
    end
    for (int i = 0; i < 5; i++) begin
      addr = ram_addr(order[i], 10);
      read_expect(addr, ram_model[addr]);
    end
  endtask

  task automatic test_unmapped();
    word_t bad_addr [2];
    word_t rd;
    logic  err;
    bad_addr = '{32'h1000_0000, 32'h2000_2000};
    for (int i = 0; i < 2; i++) begin
      apb_xfer(1'b0, bad_addr[i], '0, '0, rd, err);
      check_err(err, 1'b1, $sformatf("unmapped read of %h", bad_addr[i]));
      check_word(rd, '0, $sformatf("unmapped read data of %h", bad_addr[i]));
      apb_xfer(1'b1, bad_addr[i], next_rand(), '1, rd, err);
      check_err(err, 1'b1, $sformatf("unmapped write to %h", bad_addr[i]));
    end
    read_expect(ram_addr(2, 0), ram_model[ram_addr(2, 0)]);
  endtask

  task automatic test_gpio_io();
    gpio_pads_t exp_pads;
    word_t      pins;
    exp_pads.out = next_rand();
    exp_pads.oe  = next_rand();
    write_word(GPIO_BASE + word_t'(GPIO_OUT_OFS), exp_pads.out, '1);
    write_word(GPIO_BASE + word_t'(GPIO_OE_OFS), exp_pads.oe, '1);
    @(negedge clk);
    check_pads(pads, exp_pads, "gpio pads after register writes");
    read_expect(GPIO_BASE + word_t'(GPIO_OUT_OFS), exp_pads.out);
    read_expect(GPIO_BASE + word_t'(GPIO_OE_OFS), exp_pads.oe);
    pins = next_rand();
    @(posedge clk);
    gpio_in <= pins;
    repeat (3) @(posedge clk);
    read_expect(GPIO_BASE + word_t'(GPIO_IN_OFS), pins);
  endtask

  task automatic test_gpio_intr();
    @(posedge clk);
    gpio_in <= '0;
    repeat (4) @(posedge clk);
    write_word(GPIO_BASE + word_t'(GPIO_INTR_EN_OFS), 32'h0000_00A5, '1);
    @(negedge clk);
    check_flag(intr, 1'b0, "interrupt before any edge");
    // pins 0 and 7 enabled, pin 8 not
    @(posedge clk);
    gpio_in <= 32'h0000_0181;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag(intr, 1'b1, "interrupt after enabled rising edges");
    read_expect(GPIO_BASE + word_t'(GPIO_INTR_STATUS_OFS), 32'h0000_0081);
    write_word(GPIO_BASE + word_t'(GPIO_INTR_STATUS_OFS), 32'h0000_0081, '1);
    @(negedge clk);
    check_flag(intr, 1'b0, "interrupt after status clear");
    read_expect(GPIO_BASE + word_t'(GPIO_INTR_STATUS_OFS), '0);
    // disabled pin 9 alone
    @(posedge clk);
    gpio_in <= 32'h0000_0381;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag(intr, 1'b0, "interrupt after disabled pin edge");
    read_expect(GPIO_BASE + word_t'(GPIO_INTR_STATUS_OFS), '0);
  endtask

  task automatic test_soc_ctrl();
    word_t val;
    @(posedge clk);
    boot_sel <= 1'b0;
    read_expect(SOC_CTRL_BASE + word_t'(BOOT_SELECT_OFS), 32'd0);
    @(posedge clk);
    boot_sel <= 1'b1;
    read_expect(SOC_CTRL_BASE + word_t'(BOOT_SELECT_OFS), 32'd1);
    val = next_rand();
    write_word(SOC_CTRL_BASE + word_t'(EXIT_VALUE_OFS), val, '1);
    @(negedge clk);
    check_word(exit_value, val, "exit value output");
    check_flag(exit_valid, 1'b0, "exit valid before its write");
    write_word(SOC_CTRL_BASE + word_t'(EXIT_VALID_OFS), 32'd1, '1);
    @(negedge clk);
    check_flag(exit_valid, 1'b1, "exit valid output");
    read_expect(SOC_CTRL_BASE + word_t'(EXIT_VALID_OFS), 32'd1);
    read_expect(SOC_CTRL_BASE + word_t'(EXIT_VALUE_OFS), val);
  endtask

  initial begin
    arst_n   = 1'b0;
    req      = '0;
    boot_sel = 1'b0;
    gpio_in  = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_values();
    test_ram();
    test_unmapped();
    test_gpio_io();
    test_gpio_intr();
    test_soc_ctrl();
    if (error_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "errors recorded");
    end
  end

endmodule

`default_nettype wire

// File: hw/mini_mcu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu top: decoder, RAM banks,
// soc control, GPIO, response mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  apb_req_t              apb_req_i,
  output apb_rsp_t              apb_rsp_o,
  input  logic                  boot_select_i,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output gpio_pads_t            gpio_o,
  output logic                  gpio_intr_o,
  output logic                  exit_valid_o,
  output word_t                 exit_value_o
);

  tgt_idx_t                   tgt;
  logic                       tgt_valid;
  logic [BANK_AW-1:0]         bank_addr;
  logic [NUM_TARGETS-1:0]     tgt_sel;
  apb_rsp_t [NUM_TARGETS-1:0] tgt_rsp;

  bus_decoder u_bus_decoder (
    .apb_req_i   (apb_req_i),
    .tgt_o       (tgt),
    .tgt_valid_o (tgt_valid),
    .bank_addr_o (bank_addr)
  );

  // one select per target
  always_comb begin
    for (int t = 0; t < NUM_TARGETS; t++) begin
      tgt_sel[t] = apb_req_i.psel & tgt_valid & (int'(tgt) == t);
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    ram_bank u_ram_bank (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .sel_i     (tgt_sel[i]),
      .apb_req_i (apb_req_i),
      .addr_i    (bank_addr),
      .apb_rsp_o (tgt_rsp[i])
    );
  end

  soc_ctrl u_soc_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .sel_i         (tgt_sel[TGT_SOC_CTRL]),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (tgt_rsp[TGT_SOC_CTRL]),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  gpio_ctrl u_gpio_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (tgt_sel[TGT_GPIO]),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (tgt_rsp[TGT_GPIO]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_intr_o (gpio_intr_o)
  );

  bus_resp_mux u_bus_resp_mux (
    .tgt_i       (tgt),
    .tgt_valid_i (tgt_valid),
    .apb_req_i   (apb_req_i),
    .rsp_i       (tgt_rsp),
    .apb_rsp_o   (apb_rsp_o)
  );

endmodule

`default_nettype wire

// File: hw/gpio_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO: out/oe registers, input sync,
// rising-edge interrupts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gpio_ctrl
  import mcu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  sel_i,
  input  apb_req_t              apb_req_i,
  output apb_rsp_t              apb_rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output gpio_pads_t            gpio_o,
  output logic                  gpio_intr_o
);

  logic [PERIPH_AW-1:0]  ofs;
  logic                  access;
  logic                  wr_en;

  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] oe_q;
  logic [GPIO_WIDTH-1:0] intr_en_q;
  logic [GPIO_WIDTH-1:0] status_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] in_prev_q;

  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] status_clr;
  word_t                 rdata;

  assign ofs    = apb_req_i.paddr[PERIPH_AW-1:0];
  assign access = sel_i & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  // edge detect on the synchronised value
  assign rise       = sync2_q & ~in_prev_q;
  assign status_clr = (wr_en && ofs == GPIO_INTR_STATUS_OFS) ? apb_req_i.pwdata : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      in_prev_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q   <= gpio_i;
      sync2_q   <= sync1_q;
      in_prev_q <= sync2_q;
      // a new edge wins over a clear in the same cycle
      status_q  <= (status_q & ~status_clr) | (rise & intr_en_q);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (ofs)
        GPIO_OUT_OFS:     out_q     <= apb_req_i.pwdata;
        GPIO_OE_OFS:      oe_q      <= apb_req_i.pwdata;
        GPIO_INTR_EN_OFS: intr_en_q <= apb_req_i.pwdata;
        default:          ;
      endcase
    end
  end

  always_comb begin
    case (ofs)
      GPIO_OUT_OFS:         rdata = out_q;
      GPIO_OE_OFS:          rdata = oe_q;
      GPIO_IN_OFS:          rdata = sync2_q;
      GPIO_INTR_EN_OFS:     rdata = intr_en_q;
      GPIO_INTR_STATUS_OFS: rdata = status_q;
      default:              rdata = '0;
    endcase
  end

  assign apb_rsp_o   = '{prdata: rdata, pready: access, pslverr: 1'b0};
  assign gpio_o      = '{out: out_q, oe: oe_q};
  assign gpio_intr_o = |status_q;

  // newly set status bits belong to pins that were enabled
  a_status_enabled : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ((status_q & ~$past(status_q) & ~$past(intr_en_q)) == '0)
  ) else $error("status set on disabled pin");

endmodule

`default_nettype wire

// File: hw/soc_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on control: exit value, exit
// valid, boot select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module soc_ctrl
  import mcu_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     sel_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     boot_select_i,
  output logic     exit_valid_o,
  output word_t    exit_value_o
);

  logic [PERIPH_AW-1:0] ofs;
  logic                 access;
  logic                 wr_en;
  logic                 exit_valid_q;
  word_t                exit_value_q;
  word_t                rdata;

  assign ofs    = apb_req_i.paddr[PERIPH_AW-1:0];
  assign access = sel_i & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      // exit valid is sticky once set
      if (ofs == EXIT_VALID_OFS && apb_req_i.pwdata[0]) begin
        exit_valid_q <= 1'b1;
      end
      if (ofs == EXIT_VALUE_OFS) begin
        exit_value_q <= apb_req_i.pwdata;
      end
    end
  end

  always_comb begin
    case (ofs)
      EXIT_VALID_OFS:  rdata = word_t'(exit_valid_q);
      EXIT_VALUE_OFS:  rdata = exit_value_q;
      BOOT_SELECT_OFS: rdata = word_t'(boot_select_i);
      default:         rdata = '0;
    endcase
  end

  assign apb_rsp_o = '{prdata: rdata, pready: access, pslverr: 1'b0};

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// File: hw/bus_resp_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response mux with error reply for
// unmapped addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module bus_resp_mux
  import mcu_pkg::*;
(
  input  tgt_idx_t                   tgt_i,
  input  logic                       tgt_valid_i,
  input  apb_req_t                   apb_req_i,
  input  apb_rsp_t [NUM_TARGETS-1:0] rsp_i,
  output apb_rsp_t                   apb_rsp_o
);

  logic unmapped_access;

  // nobody claims the address, so answer here
  assign unmapped_access = ~tgt_valid_i & apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    apb_rsp_o = '0;
    if (tgt_valid_i) begin
      if (int'(tgt_i) < NUM_TARGETS) begin
        apb_rsp_o = rsp_i[tgt_i];
      end
    end else if (unmapped_access) begin
      // zero data, error, no wait states
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/ram_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single RAM bank, byte strobes, one
// wait state on reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ram_bank
  import mcu_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               sel_i,
  input  apb_req_t           apb_req_i,
  input  logic [BANK_AW-1:0] addr_i,
  output apb_rsp_t           apb_rsp_o
);

  word_t mem [BANK_WORDS];
  word_t rdata_q;
  logic  rd_wait_q;

  logic access;
  logic wr_en;
  logic rd_start;

  assign access   = sel_i & apb_req_i.penable;
  assign wr_en    = access & apb_req_i.pwrite;
  // first access cycle of a read
  assign rd_start = access & ~apb_req_i.pwrite & ~rd_wait_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_wait_q <= 1'b0;
    end else begin
      rd_wait_q <= rd_start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (apb_req_i.pstrb[b]) begin
          mem[addr_i][b*8 +: 8] <= apb_req_i.pwdata[b*8 +: 8];
        end
      end
    end
    if (rd_start) begin
      rdata_q <= mem[addr_i];
    end
  end

  // writes finish at once, reads one cycle later
  assign apb_rsp_o.prdata  = rdata_q;
  assign apb_rsp_o.pready  = access & (apb_req_i.pwrite | rd_wait_q);
  assign apb_rsp_o.pslverr = 1'b0;

  // every access phase follows a setup cycle aimed at this bank
  a_setup_before_access : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    access |-> $past(sel_i)
  ) else $error("bank access without setup cycle");

endmodule

`default_nettype wire

// File: hw/bus_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB address decoder: target index and
// bank-local word address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module bus_decoder
  import mcu_pkg::*;
(
  input  apb_req_t             apb_req_i,
  output tgt_idx_t             tgt_o,
  output logic                 tgt_valid_o,
  output logic [BANK_AW-1:0]   bank_addr_o
);

  word_t ram_ofs;
  word_t soc_ofs;
  word_t gpio_ofs;

  // offsets relative to each window base, unsigned compare below
  assign ram_ofs  = apb_req_i.paddr - RAM_BASE;
  assign soc_ofs  = apb_req_i.paddr - SOC_CTRL_BASE;
  assign gpio_ofs = apb_req_i.paddr - GPIO_BASE;

  // word within the bank, only meaningful for RAM hits
  assign bank_addr_o = ram_ofs[WORD_LSB +: BANK_AW];

  always_comb begin
    tgt_o       = '0;
    tgt_valid_o = 1'b0;
    if (ram_ofs < RAM_SIZE) begin
      // contiguous banks of BANK_BYTES each
      tgt_o       = tgt_idx_t'(ram_ofs / BANK_BYTES);
      tgt_valid_o = 1'b1;
    end else if (soc_ofs < PERIPH_SPAN) begin
      tgt_o       = TGT_SOC_CTRL;
      tgt_valid_o = 1'b1;
    end else if (gpio_ofs < PERIPH_SPAN) begin
      tgt_o       = TGT_GPIO;
      tgt_valid_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/mcu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini mcu shared package: address map,
// register offsets, APB and pad structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mcu_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned WORD_LSB   = $clog2(STRB_WIDTH);

  typedef logic [DATA_WIDTH-1:0] word_t;

  // memory banks
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);
  localparam word_t BANK_BYTES       = BANK_WORDS * STRB_WIDTH;
  localparam word_t RAM_SIZE         = NUM_BANKS * BANK_BYTES;

  // address map
  localparam word_t RAM_BASE       = 32'h0000_0000;
  localparam word_t SOC_CTRL_BASE  = 32'h2000_0000;
  localparam word_t GPIO_BASE      = 32'h2000_1000;
  localparam word_t PERIPH_SPAN    = 32'h0000_1000;
  localparam int unsigned PERIPH_AW = $clog2(PERIPH_SPAN);

  // targets: banks first, then the two peripherals
  localparam int unsigned NUM_TARGETS = NUM_BANKS + 2;
  localparam int unsigned TGT_W       = $clog2(NUM_TARGETS);

  typedef logic [TGT_W-1:0] tgt_idx_t;

  localparam tgt_idx_t TGT_SOC_CTRL = tgt_idx_t'(NUM_BANKS);
  localparam tgt_idx_t TGT_GPIO     = tgt_idx_t'(NUM_BANKS + 1);

  localparam int unsigned GPIO_WIDTH = 32;

  // soc control registers
  localparam logic [PERIPH_AW-1:0] EXIT_VALID_OFS  = 'h0;
  localparam logic [PERIPH_AW-1:0] EXIT_VALUE_OFS  = 'h4;
  localparam logic [PERIPH_AW-1:0] BOOT_SELECT_OFS = 'h8;

  // gpio registers
  localparam logic [PERIPH_AW-1:0] GPIO_OUT_OFS         = 'h0;
  localparam logic [PERIPH_AW-1:0] GPIO_OE_OFS          = 'h4;
  localparam logic [PERIPH_AW-1:0] GPIO_IN_OFS          = 'h8;
  localparam logic [PERIPH_AW-1:0] GPIO_INTR_EN_OFS     = 'hC;
  localparam logic [PERIPH_AW-1:0] GPIO_INTR_STATUS_OFS = 'h10;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_WIDTH-1:0] paddr;
    word_t                 pwdata;
    logic [STRB_WIDTH-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [GPIO_WIDTH-1:0] out;
    logic [GPIO_WIDTH-1:0] oe;
  } gpio_pads_t;

endpackage

`default_nettype wire
